/* files.f */
design/msx_cart_pkg.sv
design/cart_config_regs.sv
design/slot_select.sv
design/mapper_generic.sv
design/mapper_linear.sv
design/cart_mem_port.sv
design/cart_subsystem.sv
bench/cart_subsystem_tb.sv

/* bench/cart_subsystem_tb.sv */
`timescale 1ns/10ps

module cart_subsystem_tb;

    localparam logic [7:0] SLOT_PORT  = 8'hA8;
    // Tests take roughly 1500 cycles including reset
    localparam int         MAX_CYCLES = 4000;

    logic                                cpu_bus;
    logic                                rst;
    logic [15:0]                         addr;
    logic [7:0]                          data;
    logic                                mreq;
    logic                                iorq;
    logic                                rd;
    logic                                wr;
    logic                                req;
    logic                                cfg_we;
    logic                                cfg_slot;
    msx_cart_pkg::mapper_typ_t           cfg_typ;
    logic [msx_cart_pkg::ROM_SIZE_W-1:0] cfg_rom_size;
    logic                                mem_cs;
    logic [msx_cart_pkg::MEM_ADDR_W-1:0] mem_addr;

    // Reference model state
    logic [7:0]                          slot_m;
    msx_cart_pkg::mapper_typ_t           typ_m  [0:1];
    logic [msx_cart_pkg::ROM_SIZE_W-1:0] size_m [0:1];
    int                                  bank_m [0:1][0:7];

    // Model decode of the current cycle
    logic [1:0]                          page_slot;
    logic                                sid;
    logic                                cart;
    msx_cart_pkg::mapper_typ_t           cur_typ;
    int                                  cur_size;
    logic                                is_gen;
    int                                  blk_bytes;
    int                                  nr_blocks;
    logic                                in_win;
    logic                                bank_wr;
    int                                  new_blk;
    int                                  entry;
    int                                  rd_off;
    logic                                exp_cs;
    logic [msx_cart_pkg::MEM_ADDR_W-1:0] exp_addr;
    logic                                exp_cs_q;
    logic [msx_cart_pkg::MEM_ADDR_W-1:0] exp_addr_q;

    int err_cnt;
    int hit_cnt;
    int cycle_cnt;
    int test_num;
    int pass_cnt;
    int fail_cnt;
    int test_err0;
    int test_hit0;
    int seed_ret;

    cart_subsystem #(
        .SLOT_PORT (SLOT_PORT)
    ) i_cart_subsystem (
        .cpu_bus      (cpu_bus),
        .rst          (rst),
        .addr         (addr),
        .data         (data),
        .mreq         (mreq),
        .iorq         (iorq),
        .rd           (rd),
        .wr           (wr),
        .req          (req),
        .cfg_we       (cfg_we),
        .cfg_slot     (cfg_slot),
        .cfg_typ      (cfg_typ),
        .cfg_rom_size (cfg_rom_size),
        .mem_cs       (mem_cs),
        .mem_addr     (mem_addr)
    );

    initial begin
        cpu_bus = 1'b0;
        forever #50 cpu_bus = ~cpu_bus;
    end

    always_comb begin
        page_slot = 2'(slot_m >> (2 * int'(addr[15:14])));
        sid       = (page_slot == 2'd2);
        cart      = mreq && ((page_slot == 2'd1) || (page_slot == 2'd2));
        cur_typ   = typ_m[sid];
        cur_size  = int'(size_m[sid]);
        is_gen    = (cur_typ == msx_cart_pkg::MAPPER_GENERIC8KB)
                    || (cur_typ == msx_cart_pkg::MAPPER_GENERIC16KB);
        blk_bytes = (cur_typ == msx_cart_pkg::MAPPER_GENERIC8KB) ? 8192 : 16384;
        nr_blocks = cur_size / blk_bytes;
        in_win    = (int'(addr) >= 'h4000) && (int'(addr) <= 'hBFFF);
        bank_wr   = cart && wr && req && in_win && is_gen;
        // Block number that a bank write would store
        if (int'(data) < nr_blocks) begin
            new_blk = int'(data);
        end else begin
            new_blk = int'(data) & (nr_blocks - 1);
        end
        if (new_blk >= nr_blocks) begin
            new_blk = -1;
        end
        entry    = bank_m[sid][addr[15:13]];
        rd_off   = 0;
        exp_cs   = 1'b0;
        exp_addr = msx_cart_pkg::MEM_ADDR_NONE;
        if (cart && rd && is_gen && (entry >= 0)) begin
            rd_off = entry * blk_bytes + (int'(addr) % blk_bytes);
            if (rd_off < cur_size) begin
                exp_cs   = 1'b1;
                exp_addr = rd_off[msx_cart_pkg::MEM_ADDR_W-1:0];
            end
        end
        if (cart && rd && in_win && (cur_typ == msx_cart_pkg::MAPPER_LINEAR)) begin
            rd_off = (int'(addr) - 'h4000) & (cur_size - 1);
            if (rd_off < cur_size) begin
                exp_cs   = 1'b1;
                exp_addr = rd_off[msx_cart_pkg::MEM_ADDR_W-1:0];
            end
        end
    end

    always @(posedge cpu_bus) begin
        if (rst) begin
            slot_m     <= 8'h00;
            exp_cs_q   <= 1'b0;
            exp_addr_q <= msx_cart_pkg::MEM_ADDR_NONE;
            for (int s = 0; s < 2; s++) begin
                typ_m[s]  <= msx_cart_pkg::MAPPER_NONE;
                size_m[s] <= '0;
                for (int i = 0; i < 8; i++) begin
                    bank_m[s][i] <= ((i >= 2) && (i <= 5)) ? i - 2 : -1;
                end
            end
        end else begin
            exp_cs_q   <= exp_cs;
            exp_addr_q <= exp_addr;
            if (exp_cs) begin
                hit_cnt <= hit_cnt + 1;
            end
            if (iorq && wr && req && (addr[7:0] == SLOT_PORT)) begin
                slot_m <= data;
            end
            if (cfg_we) begin
                typ_m[cfg_slot]  <= cfg_typ;
                size_m[cfg_slot] <= cfg_rom_size;
            end
            if (bank_wr && (cur_typ == msx_cart_pkg::MAPPER_GENERIC8KB)) begin
                bank_m[sid][addr[15:13]] <= new_blk;
            end else if (bank_wr) begin
                bank_m[sid][{addr[15:14], 1'b0}] <= new_blk;
                bank_m[sid][{addr[15:14], 1'b1}] <= new_blk;
            end
        end
    end

    a_mem_cs: assert property (@(posedge cpu_bus) disable iff (rst) mem_cs == exp_cs_q)
        else begin
            err_cnt++;
            $display("Mismatch at %0t: mem_cs expected %0b, actual %0b",
                     $time, $sampled(exp_cs_q), $sampled(mem_cs));
        end

    a_mem_addr: assert property (@(posedge cpu_bus) disable iff (rst) mem_addr == exp_addr_q)
        else begin
            err_cnt++;
            $display("Mismatch at %0t: mem_addr expected %07h, actual %07h",
                     $time, $sampled(exp_addr_q), $sampled(mem_addr));
        end

    always @(posedge cpu_bus) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic drive(input int a, input int d, input logic m, input logic io,
                         input logic r, input logic w, input logic q);
        @(posedge cpu_bus);
        addr   <= 16'(a);
        data   <= 8'(d);
        mreq   <= m;
        iorq   <= io;
        rd     <= r;
        wr     <= w;
        req    <= q;
        cfg_we <= 1'b0;
    endtask

    task automatic mem_read(input int a);
        drive(a, 0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic mem_write(input int a, input int d);
        drive(a, d, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1);
    endtask

    task automatic io_write(input int port, input int d);
        drive(port, d, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1);
    endtask

    task automatic cfg_load(input logic s, input msx_cart_pkg::mapper_typ_t t, input int size);
        drive(0, 0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        cfg_we       <= 1'b1;
        cfg_slot     <= s;
        cfg_typ      <= t;
        cfg_rom_size <= 25'(size);
    endtask

    task automatic read_random(input int lo, input int hi, input int n);
        repeat (n) mem_read(int'($urandom_range(hi, lo)));
    endtask

    task automatic begin_test();
        test_err0 = err_cnt;
        test_hit0 = hit_cnt;
    endtask

    task automatic end_test(input string name, input bit need_hits);
        int errs;
        int hits;
        // Let the last read pass through the register and the check
        repeat (3) drive(0, 0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        test_num++;
        hits = hit_cnt - test_hit0;
        if (need_hits && (hits == 0)) begin
            $display("Test %0d %s: no read in the test produced a memory request", test_num, name);
            err_cnt++;
        end
        errs = err_cnt - test_err0;
        if (errs == 0) begin
            pass_cnt++;
            $display("Test %0d %s: ok, %0d requests", test_num, name, hits);
        end else begin
            fail_cnt++;
            $display("Test %0d %s: failed with %0d errors", test_num, name, errs);
        end
    endtask

    initial begin
        int base;
        int x;
        int sizes [0:1];
        seed_ret     = $urandom(32'hb60b);
        sizes[0]     = 32 * 1024;
        sizes[1]     = 48 * 1024;
        rst          = 1'b1;
        addr         = '0;
        data         = '0;
        mreq         = 1'b0;
        iorq         = 1'b0;
        rd           = 1'b0;
        wr           = 1'b0;
        req          = 1'b0;
        cfg_we       = 1'b0;
        cfg_slot     = 1'b0;
        cfg_typ      = msx_cart_pkg::MAPPER_NONE;
        cfg_rom_size = '0;
        err_cnt      = 0;
        hit_cnt      = 0;
        cycle_cnt    = 0;
        test_num     = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        repeat (8) @(posedge cpu_bus);
        rst <= 1'b0;

        begin_test();
        cfg_load(1'b0, msx_cart_pkg::MAPPER_GENERIC8KB, 128 * 1024);
        io_write(SLOT_PORT, 8'h55);
        mem_read('h0000);
        mem_read('hC000);
        read_random('h4000, 'hBFFF, 60);
        read_random('h0000, 'h3FFF, 10);
        read_random('hC000, 'hFFFF, 10);
        end_test("reset defaults", 1'b1);

        begin_test();
        for (int p = 2; p < 6; p++) begin
            base = p * 8192;
            repeat (3) begin
                mem_write(base + int'($urandom_range(8191, 0)), int'($urandom_range(15, 0)));
                read_random(base, base + 8191, 24);
            end
        end
        end_test("8 KB bank switching", 1'b1);

        // Slot 2 still holds its reset bank table
        begin_test();
        io_write(SLOT_PORT, 8'hAA);
        cfg_load(1'b1, msx_cart_pkg::MAPPER_GENERIC16KB, sizes[0]);
        read_random('h4000, 'hBFFF, 40);
        for (int k = 0; k < 2; k++) begin
            cfg_load(1'b1, msx_cart_pkg::MAPPER_GENERIC16KB, sizes[k]);
            repeat (6) begin
                mem_write(int'($urandom_range('hBFFF, 'h4000)), int'($urandom_range(255, 0)));
                read_random('h4000, 'hBFFF, 24);
            end
        end
        end_test("16 KB banks and masking", 1'b1);

        begin_test();
        repeat (16) begin
            io_write(SLOT_PORT, int'($urandom_range(255, 0)));
            io_write(SLOT_PORT + 1, int'($urandom_range(255, 0)));
            repeat (2) mem_write(int'($urandom_range('hBFFF, 'h4000)), int'($urandom_range(15, 0)));
            read_random('h0000, 'hFFFF, 20);
        end
        end_test("slot decode", 1'b1);

        begin_test();
        cfg_load(1'b1, msx_cart_pkg::MAPPER_LINEAR, 16 * 1024);
        io_write(SLOT_PORT, 8'hAA);
        repeat (40) begin
            x = int'($urandom_range('h3FFF, 0));
            mem_read('h4000 + x);
            mem_read('h8000 + x);
        end
        repeat (8) mem_write(int'($urandom_range('hBFFF, 'h4000)), int'($urandom_range(255, 0)));
        repeat (40) begin
            x = int'($urandom_range('h3FFF, 0));
            mem_read('h4000 + x);
            mem_read('h8000 + x);
        end
        // Bank table of slot 2 must be unchanged by the writes above
        cfg_load(1'b1, msx_cart_pkg::MAPPER_GENERIC16KB, sizes[1]);
        read_random('h4000, 'hBFFF, 24);
        end_test("linear mirroring", 1'b1);

        begin_test();
        io_write(SLOT_PORT, 8'h66);
        repeat (20) begin
            drive(int'($urandom_range('hFFFF, 0)), 0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
            drive(int'($urandom_range('hFFFF, 0)), 0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
            drive(int'($urandom_range('hFFFF, 0)), 0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        end
        end_test("idle output", 1'b0);

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 test_num, pass_cnt, fail_cnt, err_cnt);
        if ((fail_cnt == 0) && (err_cnt == 0)) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* design/cart_subsystem.sv */
`timescale 1ns/10ps

module cart_subsystem #(
    parameter logic [7:0] SLOT_PORT = 8'hA8
) (
    input  logic                                cpu_bus,
    input  logic                                rst,
    input  logic [15:0]                         addr,
    input  logic [7:0]                          data,
    input  logic                                mreq,
    input  logic                                iorq,
    input  logic                                rd,
    input  logic                                wr,
    input  logic                                req,
    input  logic                                cfg_we,
    input  logic                                cfg_slot,
    input  msx_cart_pkg::mapper_typ_t           cfg_typ,
    input  logic [msx_cart_pkg::ROM_SIZE_W-1:0] cfg_rom_size,
    output logic                                mem_cs,
    output logic [msx_cart_pkg::MEM_ADDR_W-1:0] mem_addr
);

    logic                                cart_mreq;
    logic                                slot_id;
    msx_cart_pkg::mapper_typ_t           typ;
    logic [msx_cart_pkg::ROM_SIZE_W-1:0] rom_size;
    logic                                gen_cs;
    logic [msx_cart_pkg::MEM_ADDR_W-1:0] gen_addr;
    logic                                lin_cs;
    logic [msx_cart_pkg::MEM_ADDR_W-1:0] lin_addr;

    slot_select #(
        .SLOT_PORT (SLOT_PORT)
    ) i_slot_select (
        .cpu_bus   (cpu_bus),
        .rst       (rst),
        .addr      (addr),
        .data      (data),
        .iorq      (iorq),
        .wr        (wr),
        .req       (req),
        .mreq      (mreq),
        .cart_mreq (cart_mreq),
        .slot_id   (slot_id)
    );

    cart_config_regs i_cart_config_regs (
        .cpu_bus      (cpu_bus),
        .rst          (rst),
        .cfg_we       (cfg_we),
        .cfg_slot     (cfg_slot),
        .cfg_typ      (cfg_typ),
        .cfg_rom_size (cfg_rom_size),
        .slot_id      (slot_id),
        .typ          (typ),
        .rom_size     (rom_size)
    );

    mapper_generic i_mapper_generic (
        .cpu_bus   (cpu_bus),
        .rst       (rst),
        .cart_mreq (cart_mreq),
        .slot_id   (slot_id),
        .typ       (typ),
        .rom_size  (rom_size),
        .addr      (addr),
        .data      (data),
        .rd        (rd),
        .wr        (wr),
        .req       (req),
        .ram_cs    (gen_cs),
        .ram_addr  (gen_addr)
    );

    mapper_linear i_mapper_linear (
        .cart_mreq (cart_mreq),
        .typ       (typ),
        .rom_size  (rom_size),
        .addr      (addr),
        .rd        (rd),
        .ram_cs    (lin_cs),
        .ram_addr  (lin_addr)
    );

    cart_mem_port i_cart_mem_port (
        .cpu_bus  (cpu_bus),
        .rst      (rst),
        .gen_cs   (gen_cs),
        .gen_addr (gen_addr),
        .lin_cs   (lin_cs),
        .lin_addr (lin_addr),
        .mem_cs   (mem_cs),
        .mem_addr (mem_addr)
    );

endmodule

/* design/cart_mem_port.sv */
`timescale 1ns/10ps

module cart_mem_port (
    input  logic                                cpu_bus,
    input  logic                                rst,
    input  logic                                gen_cs,
    input  logic [msx_cart_pkg::MEM_ADDR_W-1:0] gen_addr,
    input  logic                                lin_cs,
    input  logic [msx_cart_pkg::MEM_ADDR_W-1:0] lin_addr,
    output logic                                mem_cs,
    output logic [msx_cart_pkg::MEM_ADDR_W-1:0] mem_addr
);

    logic                                next_cs;
    logic [msx_cart_pkg::MEM_ADDR_W-1:0] next_addr;

    assign next_cs = gen_cs || lin_cs;

    // Pick the mapper that claims the cycle
    always_comb begin
        if (gen_cs) begin
            next_addr = gen_addr;
        end else if (lin_cs) begin
            next_addr = lin_addr;
        end else begin
            next_addr = msx_cart_pkg::MEM_ADDR_NONE;
        end
    end

    // One request per cycle toward memory
    always_ff @(posedge cpu_bus) begin
        if (rst) begin
            mem_cs   <= 1'b0;
            mem_addr <= msx_cart_pkg::MEM_ADDR_NONE;
        end else begin
            mem_cs   <= next_cs;
            mem_addr <= next_addr;
        end
    end

    // The slot type selects exactly one mapper family
    a_one_source: assert property (
        @(posedge cpu_bus) disable iff (rst)
        !(gen_cs && lin_cs)
    ) else $error("cart_mem_port: both mappers requested memory");

endmodule

/* design/mapper_linear.sv */
`timescale 1ns/10ps

module mapper_linear (
    input  logic                                cart_mreq,
    input  msx_cart_pkg::mapper_typ_t           typ,
    input  logic [msx_cart_pkg::ROM_SIZE_W-1:0] rom_size,
    input  logic [15:0]                         addr,
    input  logic                                rd,
    output logic                                ram_cs,
    output logic [msx_cart_pkg::MEM_ADDR_W-1:0] ram_addr
);

    localparam int PAD_W = msx_cart_pkg::MEM_ADDR_W - msx_cart_pkg::ROM_SIZE_W;

    logic                                in_window;
    logic [15:0]                         win_off;
    logic [msx_cart_pkg::ROM_SIZE_W-1:0] size_mask;
    logic [msx_cart_pkg::ROM_SIZE_W-1:0] rom_off;
    logic                                lin_valid;

    assign in_window = (addr >= msx_cart_pkg::ROM_WIN_LO) && (addr <= msx_cart_pkg::ROM_WIN_HI);

    // Offset from the start of page 1
    assign win_off = addr - msx_cart_pkg::ROM_WIN_LO;

    // Mirror inside the power of two image
    assign size_mask = rom_size - 1'b1;
    assign rom_off   = {{(msx_cart_pkg::ROM_SIZE_W-16){1'b0}}, win_off} & size_mask;

    // A zero size never passes the bound check
    assign lin_valid = (typ == msx_cart_pkg::MAPPER_LINEAR) && cart_mreq && rd && in_window
                       && (rom_off < rom_size);

    assign ram_cs   = lin_valid;
    assign ram_addr = lin_valid ? {{PAD_W{1'b0}}, rom_off} : msx_cart_pkg::MEM_ADDR_NONE;

endmodule

/* design/mapper_generic.sv */
`timescale 1ns/10ps

module mapper_generic (
    input  logic                                cpu_bus,
    input  logic                                rst,
    input  logic                                cart_mreq,
    input  logic                                slot_id,
    input  msx_cart_pkg::mapper_typ_t           typ,
    input  logic [msx_cart_pkg::ROM_SIZE_W-1:0] rom_size,
    input  logic [15:0]                         addr,
    input  logic [7:0]                          data,
    input  logic                                rd,
    input  logic                                wr,
    input  logic                                req,
    output logic                                ram_cs,
    output logic [msx_cart_pkg::MEM_ADDR_W-1:0] ram_addr
);

    // Block counter width, enough for the 8 KB block count of the largest ROM
    localparam int NB_W = msx_cart_pkg::ROM_SIZE_W - 13;
    localparam int PAD_W = msx_cart_pkg::MEM_ADDR_W - msx_cart_pkg::ROM_SIZE_W;

    logic                                is_8kb;
    logic                                is_gen;
    logic                                in_window;
    logic                                bank_we;
    logic [NB_W-1:0]                     nr_blocks;
    logic [NB_W-1:0]                     block_mask;
    logic [NB_W-1:0]                     data_ext;
    logic [NB_W-1:0]                     block_sel;
    logic [msx_cart_pkg::BANK_W-1:0]     block_entry;
    logic [msx_cart_pkg::BANK_W-1:0]     bank [0:1][0:7];
    logic [msx_cart_pkg::BANK_W-1:0]     cur_entry;
    logic [msx_cart_pkg::MEM_ADDR_W-1:0] addr_8kb;
    logic [msx_cart_pkg::MEM_ADDR_W-1:0] addr_16kb;
    logic [msx_cart_pkg::MEM_ADDR_W-1:0] addr_raw;
    logic                                ram_valid;

    assign is_8kb    = (typ == msx_cart_pkg::MAPPER_GENERIC8KB);
    assign is_gen    = is_8kb || (typ == msx_cart_pkg::MAPPER_GENERIC16KB);
    assign in_window = (addr >= msx_cart_pkg::ROM_WIN_LO) && (addr <= msx_cart_pkg::ROM_WIN_HI);
    assign bank_we   = is_gen && cart_mreq && wr && req && in_window;

    // Block count and wrap mask for the selected bank size
    assign nr_blocks  = is_8kb ? rom_size[msx_cart_pkg::ROM_SIZE_W-1:13]
                               : {1'b0, rom_size[msx_cart_pkg::ROM_SIZE_W-1:14]};
    assign block_mask = nr_blocks - 1'b1;
    assign data_ext   = {{(NB_W-8){1'b0}}, data};

    // Out of range values wrap, and are unmapped if still too large
    assign block_sel   = (data_ext < nr_blocks) ? data_ext : (data_ext & block_mask);
    assign block_entry = {(block_sel >= nr_blocks), block_sel[7:0]};

    always_ff @(posedge cpu_bus) begin
        if (rst) begin
            // Pages 1 and 2 start on blocks 0..3, the rest unmapped
            for (int s = 0; s < 2; s++) begin
                for (int i = 0; i < 8; i++) begin
                    bank[s][i] <= ((i >= 2) && (i <= 5)) ? 9'(i - 2)
                                                         : msx_cart_pkg::BANK_UNMAPPED;
                end
            end
        end else if (bank_we) begin
            if (is_8kb) begin
                bank[slot_id][addr[15:13]] <= block_entry;
            end else begin
                // 16 KB bank covers both 8 KB entries of the page
                bank[slot_id][{addr[15:14], 1'b0}] <= block_entry;
                bank[slot_id][{addr[15:14], 1'b1}] <= block_entry;
            end
        end
    end

    assign cur_entry = bank[slot_id][addr[15:13]];

    assign addr_8kb  = {6'b0, cur_entry[7:0], addr[12:0]};
    assign addr_16kb = {5'b0, cur_entry[7:0], addr[13:0]};
    assign addr_raw  = is_8kb ? addr_8kb : addr_16kb;

    // Read hits a mapped bank inside the ROM image
    assign ram_valid = is_gen && cart_mreq && rd && !cur_entry[8]
                       && (addr_raw < {{PAD_W{1'b0}}, rom_size});

    assign ram_cs   = ram_valid;
    assign ram_addr = ram_valid ? addr_raw : msx_cart_pkg::MEM_ADDR_NONE;

    // Writes only ever map entries of pages 1 and 2
    a_cs_read_window: assert property (
        @(posedge cpu_bus) disable iff (rst)
        ram_cs |-> (rd && in_window)
    ) else $error("mapper_generic: request outside a read of the ROM window");

endmodule

/* design/slot_select.sv */
`timescale 1ns/10ps

module slot_select #(
    parameter logic [7:0] SLOT_PORT = 8'hA8
) (
    input  logic        cpu_bus,
    input  logic        rst,
    input  logic [15:0] addr,
    input  logic [7:0]  data,
    input  logic        iorq,
    input  logic        wr,
    input  logic        req,
    input  logic        mreq,
    output logic        cart_mreq,
    output logic        slot_id
);

    logic [7:0] slot_reg;
    logic [1:0] page_slot;
    logic       slot_we;

    // I/O write to the primary slot register
    assign slot_we = iorq && wr && req && (addr[7:0] == SLOT_PORT);

    always_ff @(posedge cpu_bus) begin
        if (rst) begin
            slot_reg <= 8'h00;
        end else if (slot_we) begin
            slot_reg <= data;
        end
    end

    // Two bits of slot number for each 16 KB page
    always_comb begin
        case (addr[15:14])
            2'd0:    page_slot = slot_reg[1:0];
            2'd1:    page_slot = slot_reg[3:2];
            2'd2:    page_slot = slot_reg[5:4];
            default: page_slot = slot_reg[7:6];
        endcase
    end

    // Only primary slots 1 and 2 hold cartridges
    assign cart_mreq = mreq && ((page_slot == 2'd1) || (page_slot == 2'd2));
    assign slot_id   = (page_slot == 2'd2);

endmodule

/* design/cart_config_regs.sv */
`timescale 1ns/10ps

module cart_config_regs (
    input  logic                                cpu_bus,
    input  logic                                rst,
    input  logic                                cfg_we,
    input  logic                                cfg_slot,
    input  msx_cart_pkg::mapper_typ_t           cfg_typ,
    input  logic [msx_cart_pkg::ROM_SIZE_W-1:0] cfg_rom_size,
    input  logic                                slot_id,
    output msx_cart_pkg::mapper_typ_t           typ,
    output logic [msx_cart_pkg::ROM_SIZE_W-1:0] rom_size
);

    // One type and size pair per cartridge slot
    msx_cart_pkg::mapper_typ_t           typ_q  [0:1];
    logic [msx_cart_pkg::ROM_SIZE_W-1:0] size_q [0:1];

    always_ff @(posedge cpu_bus) begin
        if (rst) begin
            typ_q[0]  <= msx_cart_pkg::MAPPER_NONE;
            typ_q[1]  <= msx_cart_pkg::MAPPER_NONE;
            size_q[0] <= '0;
            size_q[1] <= '0;
        end else if (cfg_we) begin
            typ_q[cfg_slot]  <= cfg_typ;
            size_q[cfg_slot] <= cfg_rom_size;
        end
    end

    // Pair for the slot that the current page decodes to
    assign typ      = typ_q[slot_id];
    assign rom_size = size_q[slot_id];

    // A slot with a live mapper always carries a ROM image
    a_size_nonzero: assert property (
        @(posedge cpu_bus) disable iff (rst)
        (typ != msx_cart_pkg::MAPPER_NONE) |-> (rom_size != '0)
    ) else $error("cart_config_regs: mapper type set with zero ROM size");

endmodule

/* design/msx_cart_pkg.sv */
package msx_cart_pkg;

    // Mapper family of a cartridge slot, loaded through the config strobe
    typedef enum logic [1:0] {
        MAPPER_NONE        = 2'd0,
        MAPPER_LINEAR      = 2'd1,
        MAPPER_GENERIC8KB  = 2'd2,
        MAPPER_GENERIC16KB = 2'd3
    } mapper_typ_t;

    // ROM size in bytes, up to 32 MB
    localparam int ROM_SIZE_W = 25;

    // Flat external memory address, 128 MB
    localparam int MEM_ADDR_W = 27;

    // Address driven toward memory when no request is made
    localparam logic [MEM_ADDR_W-1:0] MEM_ADDR_NONE = {MEM_ADDR_W{1'b1}};

    // Cartridge ROM window seen by the mappers, pages 1 and 2
    localparam logic [15:0] ROM_WIN_LO = 16'h4000;
    localparam logic [15:0] ROM_WIN_HI = 16'hBFFF;

    // Bank table entry, bit 8 marks an unmapped bank
    localparam int BANK_W = 9;
    localparam logic [BANK_W-1:0] BANK_UNMAPPED = 9'h100;

endpackage
